//--- opl3_host_if.f
opl3_host_pkg.sv
opl3_reg_pkg.sv
synchronizer.sv
host_strobe_capture.sv
reg_write_decoder.sv
status_read_port.sv
opl3_reg_file.sv
opl3_host_if.sv
tb_clock_gen.sv
opl3_host_if_checker.sv
tb_opl3_host_if.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_opl3_host_if \
    -f opl3_host_if.f \
    --Mdir obj_dir -o sim_tb_opl3_host_if

./obj_dir/sim_tb_opl3_host_if

//--- tb_opl3_host_if.sv
`timescale 1ns/1ps
`default_nettype none

module tb_opl3_host_if;
    import opl3_host_pkg::*;
    import opl3_reg_pkg::*;

    localparam int NUM_WR          = 24;  // address/data write pairs
    localparam int NUM_PERSIST     = 4;   // data writes on one pointer
    localparam int NUM_STATUS      = 3;   // status read rounds
    localparam int NUM_ACCESSES    = 2 * NUM_WR + 1 + NUM_PERSIST + NUM_STATUS + 2;
    localparam int ACK_WINDOW      = 8;   // host gives up after this
    localparam int WATCHDOG_CYCLES = 200 * NUM_ACCESSES;

    typedef struct packed {
        reg_bank_t  bank;
        reg_index_t index;
    } ref_pointer_t;

    logic       clk;
    logic       reset;
    logic       cs_n;
    logic       rd_n;
    logic       wr_n;
    host_addr_t address;
    host_data_t din;
    host_data_t status;
    host_data_t dout;
    logic       ack_host;
    reg_bank_t  reg_rd_bank;
    reg_index_t reg_rd_index;
    reg_data_t  reg_rd_data;

    reg_data_t    ref_regs [NUM_BANKS][NUM_REG_PER_BANK];  // expected register file
    ref_pointer_t ref_pointer;          // expected bank and index pointer
    host_data_t   ref_status;           // expected dout
    reg_bank_t    wr_bank_q[$];         // targets of earlier writes
    reg_index_t   wr_index_q[$];
    integer       seed = 32'heeb4_a4b2;
    int           checks_requested = 0;  // raised by stimulus
    int           checks_done = 0;       // raised by compare process
    string        check_what;
    bit           check_is_status;

    tb_clock_gen clock_gen_inst (
        .clk   (clk),
        .reset (reset)
    );

    opl3_host_if dut (
        .clk          (clk),
        .reset        (reset),
        .cs_n         (cs_n),
        .rd_n         (rd_n),
        .wr_n         (wr_n),
        .address      (address),
        .din          (din),
        .status       (status),
        .reg_rd_bank  (reg_rd_bank),
        .reg_rd_index (reg_rd_index),
        .dout         (dout),
        .ack_host     (ack_host),
        .reg_rd_data  (reg_rd_data)
    );

    bind host_strobe_capture opl3_host_if_checker checker_inst (
        .clk          (clk),
        .reset        (reset),
        .access       (access),
        .access_valid (access_valid),
        .ack_host     (ack_host)
    );

    // expected byte for one register
    function automatic reg_data_t ref_reg_read(input reg_bank_t bank, input reg_index_t index);
        return ref_regs[bank][index];
    endfunction

    task automatic check_reg(input reg_data_t got, input reg_data_t exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s, reg_rd_data %02h, expected %02h", $time, what, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "register contents mismatch");
        end
    endtask

    task automatic check_status(input host_data_t got, input host_data_t exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s, dout %02h, expected %02h", $time, what, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "status byte mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "bus protocol failure");
    endtask

    // one host access that starts and ends on a falling edge
    task automatic bus_cycle(input logic rd, input logic wr, input host_addr_t addr,
                             input host_data_t data, input bit expect_ack);
        bit seen;
        seen    = 1'b0;
        cs_n    = 1'b0;
        rd_n    = ~rd;
        wr_n    = ~wr;
        address = addr;
        din     = data;
        for (int n = 0; n < ACK_WINDOW && !seen; n++) begin
            @(negedge clk);
            seen = ack_host;            // ack is stable between edges
        end
        if (expect_ack && !seen) begin
            abort_run($sformatf("no ack_host within %0d cycles of a legal access", ACK_WINDOW));
        end
        if (!expect_ack && seen) begin
            abort_run("ack_host came back for an access that should be dropped");
        end
        cs_n = 1'b1;                    // release so the capture re-arms
        rd_n = 1'b1;
        wr_n = 1'b1;
        repeat (4) @(negedge clk);
    endtask

    task automatic addr_write(input reg_bank_t bank, input reg_index_t index);
        bus_cycle(1'b0, 1'b1, {bank, 1'b0}, index, 1'b1);
        ref_pointer.bank  = bank;
        ref_pointer.index = index;
    endtask

    task automatic data_write(input host_data_t data);
        bus_cycle(1'b0, 1'b1, 2'b01, data, 1'b1);
        ref_regs[ref_pointer.bank][ref_pointer.index] = data;  // last write wins
    endtask

    task automatic status_read(input host_addr_t addr);
        ref_status = status;            // held stable by the caller
        bus_cycle(1'b1, 1'b0, addr, 8'h00, 1'b1);
    endtask

    task automatic drop_access(input logic rd, input logic wr, input host_data_t data);
        bus_cycle(rd, wr, 2'b01, data, 1'b0);  // model untouched
    endtask

    // blocks until the compare process has handled the request
    task automatic request_compare();
        checks_requested++;
        wait (checks_done == checks_requested);
    endtask

    // hand one register read to the compare process
    task automatic read_check(input reg_bank_t bank, input reg_index_t index, input string what);
        reg_rd_bank  = bank;
        reg_rd_index = index;
        @(negedge clk);                 // read port settled
        check_what      = what;
        check_is_status = 1'b0;
        request_compare();
    endtask

    task automatic status_check(input string what);
        check_what      = what;
        check_is_status = 1'b1;
        request_compare();
    endtask

    task automatic scan_all(input string what);
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int i = 0; i < NUM_REG_PER_BANK; i++) begin
                read_check(reg_bank_t'(b), reg_index_t'(i), what);
            end
        end
    endtask

    // compare process
    always begin
        wait (checks_done != checks_requested);
        if (check_is_status) begin
            check_status(dout, ref_status, check_what);
        end else begin
            check_reg(reg_rd_data, ref_reg_read(reg_rd_bank, reg_rd_index), check_what);
        end
        checks_done++;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run still going after %0d cycles", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        reg_bank_t   bank;
        logic [31:0] rnd;
        cs_n         = 1'b1;
        rd_n         = 1'b1;
        wr_n         = 1'b1;
        address      = '0;
        din          = '0;
        status       = '0;
        reg_rd_bank  = '0;
        reg_rd_index = '0;
        ref_regs     = '{default: '0};
        ref_pointer  = '0;
        ref_status   = '0;
        @(negedge clk);
        while (reset) @(negedge clk);

        // reset state at corners plus random samples
        read_check(1'b0, 8'h00, "after reset");
        read_check(1'b0, 8'hff, "after reset");
        read_check(1'b1, 8'h00, "after reset");
        read_check(1'b1, 8'hff, "after reset");
        for (int n = 0; n < 12; n++) begin
            rnd = $random(seed);
            read_check(rnd[8], rnd[7:0], "after reset");
        end
        status_check("dout after reset");

        // write and read back with alternating banks
        for (int n = 0; n < NUM_WR; n++) begin
            rnd  = $random(seed);
            bank = n[0];
            addr_write(bank, rnd[7:0]);
            data_write(rnd[15:8]);
            wr_bank_q.push_back(bank);
            wr_index_q.push_back(rnd[7:0]);
            read_check(bank, rnd[7:0], "write readback");
        end

        // pointer persists across data writes
        rnd = $random(seed);
        addr_write(1'b1, rnd[7:0]);
        for (int k = 0; k < NUM_PERSIST; k++) begin
            rnd = $random(seed);
            data_write(rnd[7:0]);
            read_check(ref_pointer.bank, ref_pointer.index, "repeated data write");
        end
        foreach (wr_bank_q[n]) begin
            read_check(wr_bank_q[n], wr_index_q[n], "earlier write kept");
        end

        // status snapshot held until next read, address varies per round
        for (int n = 0; n < NUM_STATUS; n++) begin
            rnd    = $random(seed);
            status = rnd[7:0];
            repeat (4) @(negedge clk);  // past the status sync
            status_read(host_addr_t'(n));
            status_check("status read");
            status = ~rnd[7:0];
            repeat (6) @(negedge clk);
            status_check("dout held after status change");
        end

        // both strobes and then neither
        rnd = $random(seed);
        drop_access(1'b1, 1'b1, rnd[7:0]);
        drop_access(1'b0, 1'b0, rnd[15:8]);
        scan_all("after dropped access");

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- opl3_host_if_checker.sv
`timescale 1ns/1ps
`default_nettype none

module opl3_host_if_checker (
    input wire                            clk,
    input wire                            reset,
    input wire opl3_host_pkg::host_access_t access,
    input wire                            access_valid,
    input wire                            ack_host
);
    import opl3_host_pkg::*;

    // one access per cs assertion
    single_pulse: assert property (@(posedge clk) disable iff (reset)
        access_valid |=> !access_valid)
        else $error("access_valid high two cycles in a row");

    // host ack tracks the internal pulse exactly
    ack_follows_valid: assert property (@(posedge clk) disable iff (reset)
        ack_host == access_valid)
        else $error("ack_host differs from access_valid");

    // illegal strobe pairs stay inside the capture
    no_none_issued: assert property (@(posedge clk) disable iff (reset)
        access_valid |-> access.kind != ACC_NONE)
        else $error("ACC_NONE issued with access_valid");

    // sync reset leaves both pulses low
    reset_clears: assert property (@(posedge clk)
        reset |=> (!access_valid && !ack_host))
        else $error("access_valid or ack_host high after a reset cycle");

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);
    localparam int RESET_CYCLES = 10;  // rising edges with reset held

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;          // 8 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;                  // released after the 10th edge
    end

endmodule

`default_nettype wire

//--- opl3_host_if.sv
`timescale 1ns/1ps
`default_nettype none

module opl3_host_if (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          cs_n,         // host chip select
    input  wire                          rd_n,         // host read strobe
    input  wire                          wr_n,         // host write strobe
    input  wire opl3_host_pkg::host_addr_t address,
    input  wire opl3_host_pkg::host_data_t din,
    input  wire opl3_host_pkg::host_data_t status,     // from outside clk domain
    input  wire opl3_reg_pkg::reg_bank_t  reg_rd_bank,
    input  wire opl3_reg_pkg::reg_index_t reg_rd_index,
    output opl3_host_pkg::host_data_t    dout,
    output logic                         ack_host,     // one pulse per access
    output opl3_reg_pkg::reg_data_t      reg_rd_data
);
    import opl3_host_pkg::*;
    import opl3_reg_pkg::*;

    host_access_t access;               // classified host access
    logic         access_valid;
    reg_write_t   reg_wr;               // decoded register write
    logic         reg_wr_valid;

    // bus sync, edge detect and classification
    host_strobe_capture capture_inst (
        .clk          (clk),
        .reset        (reset),
        .cs_n         (cs_n),
        .rd_n         (rd_n),
        .wr_n         (wr_n),
        .address      (address),
        .din          (din),
        .access       (access),
        .access_valid (access_valid),
        .ack_host     (ack_host)
    );

    // address and data writes into register writes
    reg_write_decoder decoder_inst (
        .clk          (clk),
        .reset        (reset),
        .access       (access),
        .access_valid (access_valid),
        .reg_wr       (reg_wr),
        .reg_wr_valid (reg_wr_valid)
    );

    // status reads, beside the decoder
    status_read_port status_inst (
        .clk          (clk),
        .reset        (reset),
        .status       (status),
        .access       (access),
        .access_valid (access_valid),
        .dout         (dout)
    );

    opl3_reg_file reg_file_inst (
        .clk          (clk),
        .reset        (reset),
        .reg_wr       (reg_wr),
        .reg_wr_valid (reg_wr_valid),
        .rd_bank      (reg_rd_bank),
        .rd_index     (reg_rd_index),
        .rd_data      (reg_rd_data)
    );

endmodule

`default_nettype wire

//--- opl3_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module opl3_reg_file (
    input  wire                          clk,
    input  wire                          reset,
    input  wire opl3_reg_pkg::reg_write_t reg_wr,
    input  wire                          reg_wr_valid,
    input  wire opl3_reg_pkg::reg_bank_t  rd_bank,
    input  wire opl3_reg_pkg::reg_index_t rd_index,
    output opl3_reg_pkg::reg_data_t      rd_data
);
    import opl3_reg_pkg::*;

    reg_data_t regs [NUM_BANKS][NUM_REG_PER_BANK];  // both banks of registers

    always_ff @(posedge clk) begin
        if (reset) begin
            // whole file cleared, engine starts from silence
            for (int b = 0; b < NUM_BANKS; b++) begin
                for (int i = 0; i < NUM_REG_PER_BANK; i++) begin
                    regs[b][i] <= '0;
                end
            end
        end else if (reg_wr_valid) begin
            regs[reg_wr.bank][reg_wr.index] <= reg_wr.data;  // write on every pulse
        end
    end

    // read port for the synthesis engine, no latency
    assign rd_data = regs[rd_bank][rd_index];

endmodule

`default_nettype wire

//--- status_read_port.sv
`timescale 1ns/1ps
`default_nettype none

module status_read_port (
    input  wire                          clk,
    input  wire                          reset,
    input  wire opl3_host_pkg::host_data_t   status,
    input  wire opl3_host_pkg::host_access_t access,
    input  wire                          access_valid,
    output opl3_host_pkg::host_data_t    dout
);
    import opl3_host_pkg::*;

    host_data_t status_sync;            // status two clocks old

    // bits need no coherence, a plain vector sync is enough
    synchronizer #(
        .WIDTH($bits(host_data_t))
    ) status_sync_inst (
        .clk   (clk),
        .reset (reset),
        .in    (status),
        .out   (status_sync)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            dout <= '0;
        end else if (access_valid && access.kind == ACC_STATUS_RD) begin
            dout <= status_sync;        // snapshot, held until next read
        end
    end

endmodule

`default_nettype wire

//--- reg_write_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module reg_write_decoder (
    input  wire                          clk,
    input  wire                          reset,
    input  wire opl3_host_pkg::host_access_t access,
    input  wire                          access_valid,
    output opl3_reg_pkg::reg_write_t     reg_wr,
    output logic                         reg_wr_valid
);
    import opl3_host_pkg::*;
    import opl3_reg_pkg::*;

    reg_bank_t  ptr_bank;               // bank picked by last address write
    reg_index_t ptr_index;              // register picked by last address write
    logic       is_data_wr;

    assign is_data_wr = access_valid && (access.kind == ACC_DATA_WR);

    // pointer and write pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            ptr_bank     <= '0;
            ptr_index    <= '0;
            reg_wr_valid <= 1'b0;
        end else begin
            reg_wr_valid <= is_data_wr;         // one write per data access
            if (access_valid && access.kind == ACC_ADDR_WR) begin
                ptr_bank  <= access.addr[1];    // bank from address bit 1
                ptr_index <= reg_index_t'(access.data);
            end
        end
    end

    // pointer kept as is, repeated data writes hit the same register
    always_ff @(posedge clk) begin
        if (is_data_wr) begin
            reg_wr.bank  <= ptr_bank;
            reg_wr.index <= ptr_index;
            reg_wr.data  <= reg_data_t'(access.data);
        end
    end

endmodule

`default_nettype wire

//--- host_strobe_capture.sv
`timescale 1ns/1ps
`default_nettype none

module host_strobe_capture (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         cs_n,
    input  wire                         rd_n,
    input  wire                         wr_n,
    input  wire opl3_host_pkg::host_addr_t address,
    input  wire opl3_host_pkg::host_data_t din,
    output opl3_host_pkg::host_access_t access,
    output logic                        access_valid,
    output logic                        ack_host
);
    import opl3_host_pkg::*;

    localparam int BUS_W = $bits(host_addr_t) + $bits(host_data_t);  // address and din

    typedef enum logic [1:0] {
        IDLE,                           // armed, waiting for cs edge
        ISSUE,                          // classified access pending
        WAIT_RELEASE                    // hold off until host drops cs
    } capture_state_t;

    capture_state_t   state;
    logic [2:0]       strobe_sync;      // {cs, rd, wr}, active high after sync
    logic [BUS_W-1:0] bus_sync;         // {address, din} after sync
    host_addr_t       addr_sync;
    host_data_t       din_sync;
    logic             cs_prev;          // edge register on synced cs
    logic             cs_rise;
    access_kind_t     kind_next;

    // strobes inverted first so the reset value of zero means idle
    synchronizer #(
        .WIDTH(3)
    ) strobe_sync_inst (
        .clk   (clk),
        .reset (reset),
        .in    ({~cs_n, ~rd_n, ~wr_n}),
        .out   (strobe_sync)
    );

    synchronizer #(
        .WIDTH(BUS_W)
    ) bus_sync_inst (
        .clk   (clk),
        .reset (reset),
        .in    ({address, din}),
        .out   (bus_sync)
    );

    assign addr_sync = bus_sync[BUS_W-1 -: $bits(host_addr_t)];
    assign din_sync  = bus_sync[$bits(host_data_t)-1:0];
    assign cs_rise   = strobe_sync[2] & ~cs_prev;  // cs assertion edge

    // sort the access by the rd/wr pair and the write mode bit
    always_comb begin
        case ({strobe_sync[1], strobe_sync[0]})
            2'b01:   kind_next = addr_sync[0] ? ACC_DATA_WR : ACC_ADDR_WR;
            2'b10:   kind_next = ACC_STATUS_RD;  // any read returns status
            default: kind_next = ACC_NONE;      // both or neither strobe
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= IDLE;
            cs_prev      <= 1'b0;
            access_valid <= 1'b0;
            ack_host     <= 1'b0;
        end else begin
            cs_prev      <= strobe_sync[2];
            access_valid <= 1'b0;               // pulses by default
            ack_host     <= 1'b0;
            case (state)
                IDLE: begin
                    if (cs_rise) begin
                        // ACC_NONE skips the issue and gets no ack
                        state <= (kind_next != ACC_NONE) ? ISSUE : WAIT_RELEASE;
                    end
                end
                ISSUE: begin
                    access_valid <= 1'b1;       // one access per cs assertion
                    ack_host     <= 1'b1;
                    state        <= WAIT_RELEASE;
                end
                WAIT_RELEASE: begin
                    if (!strobe_sync[2]) begin
                        state <= IDLE;          // re-arm once cs released
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // payload latched on the edge and held until the next access
    always_ff @(posedge clk) begin
        if (state == IDLE && cs_rise) begin
            access.kind <= kind_next;
            access.addr <= addr_sync;
            access.data <= din_sync;
        end
    end

endmodule

`default_nettype wire

//--- synchronizer.sv
`timescale 1ns/1ps
`default_nettype none

module synchronizer #(
    parameter int WIDTH = 1             // bits carried through the chain
) (
    input  wire              clk,
    input  wire              reset,
    input  wire  [WIDTH-1:0] in,        // sampled from outside the clk domain
    output logic [WIDTH-1:0] out        // safe to use in the clk domain
);
    import opl3_host_pkg::*;

    logic [SYNC_STAGES-1:0][WIDTH-1:0] stage;  // stage 0 is the metastable one

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= '0;
        end else begin
            stage <= {stage[SYNC_STAGES-2:0], in};  // shift one stage per clock
        end
    end

    assign out = stage[SYNC_STAGES-1];  // last stage only

endmodule

`default_nettype wire

//--- opl3_reg_pkg.sv
`default_nettype none

// register file side definitions: geometry and write port
package opl3_reg_pkg;

    localparam int NUM_BANKS        = 2;    // opl3 has two register arrays
    localparam int NUM_REG_PER_BANK = 256;  // full 8-bit index space per bank

    typedef logic       reg_bank_t;         // bank number
    typedef logic [7:0] reg_index_t;        // register index within a bank
    typedef logic [7:0] reg_data_t;         // register contents

    // single register write, bank and index taken from the pointer
    typedef struct packed {
        reg_bank_t  bank;                   // target bank
        reg_index_t index;                  // target register
        reg_data_t  data;                   // byte to store
    } reg_write_t;

endpackage

`default_nettype wire

//--- opl3_host_pkg.sv
`default_nettype none

// host bus side definitions: bus widths, access kinds, captured access
package opl3_host_pkg;

    localparam int SYNC_STAGES = 2;     // flop depth of every synchronizer

    typedef logic [7:0] host_data_t;    // host data bus and status byte
    typedef logic [1:0] host_addr_t;    // bit 0 addr/data mode, bit 1 bank

    // sorted access, taken once per cs assertion
    typedef enum logic [1:0] {
        ACC_NONE,                       // illegal strobe combination, dropped
        ACC_ADDR_WR,                    // select bank and register index
        ACC_DATA_WR,                    // write byte at current pointer
        ACC_STATUS_RD                   // snapshot status onto dout
    } access_kind_t;

    // one captured access as issued by the capture stage
    typedef struct packed {
        access_kind_t kind;             // what the host asked for
        host_addr_t   addr;             // address bus at cs edge
        host_data_t   data;             // din at cs edge
    } host_access_t;

endpackage

`default_nettype wire
